/* Makefile */
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := exec_stage_tb
FILELIST   := files.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
+incdir+source
source/isa_pkg.sv
source/exec_pkg.sv
source/operand_select.sv
source/alu.sv
source/branch_unit.sv
source/writeback_arbiter.sv
source/exec_stage.sv
tb/exec_stage_chk.sv
tb/exec_stage_tb.sv

/* source/alu.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module alu (
    input  logic                       clock,
    input  logic                       arst_n,
    input  logic                       issue,
    input  isa_pkg::rv_inst_u          inst,
    input  logic [`EXEC_XLEN-1:0]      pc,
    input  logic [`EXEC_XLEN-1:0]      rs1_value,
    input  logic [`EXEC_XLEN-1:0]      rs2_value,
    input  isa_pkg::opa_sel_e          opa_sel,
    input  isa_pkg::opb_sel_e          opb_sel,
    input  isa_pkg::alu_func_e         alu_func,
    input  logic [`EXEC_TAG_W-1:0]     dest_tag,
    input  logic [`EXEC_BMASK_W-1:0]   b_mask,
    input  exec_pkg::br_task_e         br_task,
    input  logic [`EXEC_BMASK_W-1:0]   br_id,
    input  logic                       stall,
    output logic                       done,
    output logic [`EXEC_XLEN-1:0]      result,
    output logic [`EXEC_TAG_W-1:0]     done_tag
);
    import isa_pkg::*;
    import exec_pkg::*;

    logic [`EXEC_XLEN-1:0]    opa;
    logic [`EXEC_XLEN-1:0]    opb;
    logic [`EXEC_XLEN-1:0]    alu_out;
    logic [`EXEC_BMASK_W-1:0] in_mask;
    logic [`EXEC_BMASK_W-1:0] held_mask;
    logic                     squash_in;
    logic                     squash_held;
    logic                     capture;

    operand_select u_opsel (
        .inst      (inst),
        .pc        (pc),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .opa_sel   (opa_sel),
        .opb_sel   (opb_sel),
        .opa       (opa),
        .opb       (opb)
    );

    always_comb begin
        case (alu_func)
            ALU_ADD:  alu_out = opa + opb;
            ALU_SUB:  alu_out = opa - opb;
            ALU_AND:  alu_out = opa & opb;
            ALU_OR:   alu_out = opa | opb;
            ALU_XOR:  alu_out = opa ^ opb;
            ALU_SLT:  alu_out = {{(`EXEC_XLEN-1){1'b0}}, $signed(opa) < $signed(opb)};
            ALU_SLTU: alu_out = {{(`EXEC_XLEN-1){1'b0}}, opa < opb};
            // shift amount is the low five bits only
            ALU_SLL:  alu_out = opa << opb[4:0];
            ALU_SRL:  alu_out = opa >> opb[4:0];
            ALU_SRA:  alu_out = $unsigned($signed(opa) >>> opb[4:0]);
            default:  alu_out = '0;
        endcase
    end

    // incoming mask with a resolving branch already removed
    assign in_mask     = (br_task == CLEAR) ? (b_mask & ~br_id) : b_mask;
    assign squash_in   = (br_task == SQUASH) && ((b_mask & br_id) != '0);
    assign squash_held = (br_task == SQUASH) && ((held_mask & br_id) != '0);
    assign capture     = issue && !stall && !squash_in;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            done <= 1'b0;
        end else if (stall) begin
            // held result survives unless its branch mispredicted
            done <= done && !squash_held;
        end else begin
            done <= capture;
        end
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            result    <= alu_out;
            done_tag  <= dest_tag;
            held_mask <= in_mask;
        end else if (br_task == CLEAR) begin
            held_mask <= held_mask & ~br_id;
        end
    end

endmodule

/* source/branch_unit.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module branch_unit (
    input  logic                       clock,
    input  logic                       arst_n,
    input  logic                       issue,
    input  isa_pkg::rv_inst_u          inst,
    input  logic [`EXEC_XLEN-1:0]      pc,
    input  logic [`EXEC_XLEN-1:0]      rs1_value,
    input  logic [`EXEC_XLEN-1:0]      rs2_value,
    input  logic [`EXEC_TAG_W-1:0]     dest_tag,
    input  logic [`EXEC_BMASK_W-1:0]   b_mask,
    input  logic                       pred_taken,
    input  exec_pkg::br_task_e         br_task,
    input  logic [`EXEC_BMASK_W-1:0]   br_id,
    input  logic                       stall,
    output logic                       done,
    output logic                       writes,
    output logic [`EXEC_XLEN-1:0]      link_value,
    output logic [`EXEC_TAG_W-1:0]     done_tag,
    output logic                       res_valid,
    output logic                       res_taken,
    output logic [`EXEC_XLEN-1:0]      res_target,
    output logic                       res_mispredict,
    output logic [`EXEC_TAG_W-1:0]     res_tag
);
    import isa_pkg::*;
    import exec_pkg::*;

    opa_sel_e                 tgt_a_sel;
    opb_sel_e                 tgt_b_sel;
    logic [`EXEC_XLEN-1:0]    tgt_a;
    logic [`EXEC_XLEN-1:0]    tgt_b;
    logic [`EXEC_XLEN-1:0]    tgt_sum;
    logic                     is_jal;
    logic                     is_jalr;
    logic                     cond;
    logic                     taken;
    logic [`EXEC_BMASK_W-1:0] in_mask;
    logic [`EXEC_BMASK_W-1:0] held_mask;
    logic                     squash_in;
    logic                     squash_held;
    logic                     hold;
    logic                     capture;

    assign is_jal  = (inst.j.opcode == OPC_JAL);
    assign is_jalr = (inst.i.opcode == OPC_JALR);

    // target base and offset follow the opcode
    always_comb begin
        tgt_a_sel = OPA_PC;
        tgt_b_sel = OPB_B_IMM;
        if (is_jal) begin
            tgt_b_sel = OPB_J_IMM;
        end else if (is_jalr) begin
            tgt_a_sel = OPA_RS1;
            tgt_b_sel = OPB_I_IMM;
        end
    end

    operand_select u_opsel (
        .inst      (inst),
        .pc        (pc),
        .rs1_value (rs1_value),
        .rs2_value (rs2_value),
        .opa_sel   (tgt_a_sel),
        .opb_sel   (tgt_b_sel),
        .opa       (tgt_a),
        .opb       (tgt_b)
    );

    assign tgt_sum = tgt_a + tgt_b;

    always_comb begin
        case (inst.b.funct3)
            F3_BEQ:  cond = (rs1_value == rs2_value);
            F3_BNE:  cond = (rs1_value != rs2_value);
            F3_BLT:  cond = ($signed(rs1_value) < $signed(rs2_value));
            F3_BGE:  cond = ($signed(rs1_value) >= $signed(rs2_value));
            F3_BLTU: cond = (rs1_value < rs2_value);
            F3_BGEU: cond = (rs1_value >= rs2_value);
            default: cond = 1'b0;
        endcase
    end

    assign taken = is_jal || is_jalr || cond;

    assign in_mask     = (br_task == CLEAR) ? (b_mask & ~br_id) : b_mask;
    assign squash_in   = (br_task == SQUASH) && ((b_mask & br_id) != '0);
    assign squash_held = (br_task == SQUASH) && ((held_mask & br_id) != '0);
    // only a jump waits for the writeback port
    assign hold        = stall && writes;
    assign capture     = issue && !hold && !squash_in;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            done      <= 1'b0;
            res_valid <= 1'b0;
        end else begin
            res_valid <= capture;
            if (hold) begin
                done <= done && !squash_held;
            end else begin
                done <= capture;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (capture) begin
            writes         <= is_jal || is_jalr;
            link_value     <= pc + `EXEC_XLEN'd4;
            done_tag       <= dest_tag;
            held_mask      <= in_mask;
            res_taken      <= taken;
            // B and J offsets are even, so this only affects JALR
            res_target     <= {tgt_sum[`EXEC_XLEN-1:1], 1'b0};
            res_mispredict <= (taken != pred_taken);
            res_tag        <= dest_tag;
        end else if (br_task == CLEAR) begin
            held_mask <= held_mask & ~br_id;
        end
    end

endmodule

/* source/exec_config.svh */
`ifndef EXEC_CONFIG_SVH
`define EXEC_CONFIG_SVH

// datapath and address width
`define EXEC_XLEN 32

// one bit per unresolved branch in flight
`define EXEC_BMASK_W 4

// physical destination register tag
`define EXEC_TAG_W 6

`endif

/* source/exec_pkg.sv */
package exec_pkg;

    // action requested by branch resolution on every in-flight mask
    typedef enum logic [1:0] {
        // nothing to do this cycle
        NONE   = 2'd0,
        // branch resolved correctly, drop its bit
        CLEAR  = 2'd1,
        // mispredict, kill everything that depends on it
        SQUASH = 2'd2
    } br_task_e;

    // unit that owns the writeback port this cycle
    typedef enum logic {
        WB_ALU    = 1'b0,
        WB_BRANCH = 1'b1
    } wb_src_e;

endpackage

/* source/exec_stage.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_stage (
    input  logic                       clock,
    input  logic                       arst_n,
    input  isa_pkg::rv_inst_u          inst,
    input  logic [`EXEC_XLEN-1:0]      pc,
    input  logic [`EXEC_XLEN-1:0]      rs1_value,
    input  logic [`EXEC_XLEN-1:0]      rs2_value,
    input  isa_pkg::opa_sel_e          opa_sel,
    input  isa_pkg::opb_sel_e          opb_sel,
    input  isa_pkg::alu_func_e         alu_func,
    input  logic [`EXEC_TAG_W-1:0]     dest_tag,
    input  logic [`EXEC_BMASK_W-1:0]   b_mask,
    input  logic                       pred_taken,
    input  logic                       alu_issue,
    input  logic                       br_issue,
    input  exec_pkg::br_task_e         br_task,
    input  logic [`EXEC_BMASK_W-1:0]   br_id,
    output logic                       wb_valid,
    output logic [`EXEC_TAG_W-1:0]     wb_tag,
    output logic [`EXEC_XLEN-1:0]      wb_value,
    output exec_pkg::wb_src_e          wb_src,
    output logic                       res_valid,
    output logic                       res_taken,
    output logic [`EXEC_XLEN-1:0]      res_target,
    output logic                       res_mispredict,
    output logic [`EXEC_TAG_W-1:0]     res_tag,
    output logic                       alu_stall,
    output logic                       br_stall
);
    logic                   alu_done;
    logic [`EXEC_XLEN-1:0]  alu_result;
    logic [`EXEC_TAG_W-1:0] alu_tag;
    logic                   br_done;
    logic                   br_writes;
    logic [`EXEC_XLEN-1:0]  br_link;
    logic [`EXEC_TAG_W-1:0] br_tag;

    alu u_alu (
        .clock (clock), .arst_n (arst_n), .issue (alu_issue),
        .inst (inst), .pc (pc), .rs1_value (rs1_value), .rs2_value (rs2_value),
        .opa_sel (opa_sel), .opb_sel (opb_sel), .alu_func (alu_func),
        .dest_tag (dest_tag), .b_mask (b_mask), .br_task (br_task), .br_id (br_id),
        .stall (alu_stall), .done (alu_done), .result (alu_result), .done_tag (alu_tag)
    );

    branch_unit u_branch (
        .clock (clock), .arst_n (arst_n), .issue (br_issue),
        .inst (inst), .pc (pc), .rs1_value (rs1_value), .rs2_value (rs2_value),
        .dest_tag (dest_tag), .b_mask (b_mask), .pred_taken (pred_taken),
        .br_task (br_task), .br_id (br_id), .stall (br_stall),
        .done (br_done), .writes (br_writes), .link_value (br_link), .done_tag (br_tag),
        .res_valid (res_valid), .res_taken (res_taken), .res_target (res_target),
        .res_mispredict (res_mispredict), .res_tag (res_tag)
    );

    writeback_arbiter u_arb (
        .alu_done (alu_done), .alu_result (alu_result), .alu_tag (alu_tag),
        .br_done (br_done), .br_writes (br_writes), .br_link (br_link), .br_tag (br_tag),
        .wb_valid (wb_valid), .wb_tag (wb_tag), .wb_value (wb_value), .wb_src (wb_src),
        .alu_stall (alu_stall), .br_stall (br_stall)
    );

endmodule

/* source/isa_pkg.sv */
package isa_pkg;

    // RV32I instruction word and its per-format views
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [6:0] funct7;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] rd;
            logic [6:0] opcode;
        } r;
        struct packed {
            logic [11:0] imm;
            logic [4:0]  rs1;
            logic [2:0]  funct3;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } i;
        struct packed {
            logic [6:0] imm_hi;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s;
        struct packed {
            logic       imm12;
            logic [5:0] imm10_5;
            logic [4:0] rs2;
            logic [4:0] rs1;
            logic [2:0] funct3;
            logic [3:0] imm4_1;
            logic       imm11;
            logic [6:0] opcode;
        } b;
        struct packed {
            logic [19:0] imm;
            logic [4:0]  rd;
            logic [6:0]  opcode;
        } u;
        struct packed {
            logic       imm20;
            logic [9:0] imm10_1;
            logic       imm11;
            logic [7:0] imm19_12;
            logic [4:0] rd;
            logic [6:0] opcode;
        } j;
    } rv_inst_u;

    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;

    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;

    typedef enum logic [1:0] {
        OPA_RS1,
        OPA_NPC,
        OPA_PC,
        OPA_ZERO
    } opa_sel_e;

    typedef enum logic [2:0] {
        OPB_RS2,
        OPB_I_IMM,
        OPB_S_IMM,
        OPB_B_IMM,
        OPB_U_IMM,
        OPB_J_IMM
    } opb_sel_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_SRA
    } alu_func_e;

endpackage

/* source/operand_select.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module operand_select (
    input  isa_pkg::rv_inst_u        inst,
    input  logic [`EXEC_XLEN-1:0]    pc,
    input  logic [`EXEC_XLEN-1:0]    rs1_value,
    input  logic [`EXEC_XLEN-1:0]    rs2_value,
    input  isa_pkg::opa_sel_e        opa_sel,
    input  isa_pkg::opb_sel_e        opb_sel,
    output logic [`EXEC_XLEN-1:0]    opa,
    output logic [`EXEC_XLEN-1:0]    opb
);
    import isa_pkg::*;

    logic [`EXEC_XLEN-1:0] i_imm;
    logic [`EXEC_XLEN-1:0] s_imm;
    logic [`EXEC_XLEN-1:0] b_imm;
    logic [`EXEC_XLEN-1:0] u_imm;
    logic [`EXEC_XLEN-1:0] j_imm;

    // sign extension from the top bit of each format
    assign i_imm = {{20{inst.i.imm[11]}}, inst.i.imm};
    assign s_imm = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
    assign b_imm = {{19{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                    inst.b.imm10_5, inst.b.imm4_1, 1'b0};
    assign u_imm = {inst.u.imm, 12'b0};
    assign j_imm = {{11{inst.j.imm20}}, inst.j.imm20, inst.j.imm19_12,
                    inst.j.imm11, inst.j.imm10_1, 1'b0};

    always_comb begin
        case (opa_sel)
            OPA_RS1:  opa = rs1_value;
            // address of the next sequential instruction
            OPA_NPC:  opa = pc + `EXEC_XLEN'd4;
            OPA_PC:   opa = pc;
            OPA_ZERO: opa = '0;
            default:  opa = '0;
        endcase
    end

    always_comb begin
        case (opb_sel)
            OPB_RS2:   opb = rs2_value;
            OPB_I_IMM: opb = i_imm;
            OPB_S_IMM: opb = s_imm;
            OPB_B_IMM: opb = b_imm;
            OPB_U_IMM: opb = u_imm;
            OPB_J_IMM: opb = j_imm;
            default:   opb = '0;
        endcase
    end

endmodule

/* source/writeback_arbiter.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module writeback_arbiter (
    input  logic                     alu_done,
    input  logic [`EXEC_XLEN-1:0]    alu_result,
    input  logic [`EXEC_TAG_W-1:0]   alu_tag,
    input  logic                     br_done,
    input  logic                     br_writes,
    input  logic [`EXEC_XLEN-1:0]    br_link,
    input  logic [`EXEC_TAG_W-1:0]   br_tag,
    output logic                     wb_valid,
    output logic [`EXEC_TAG_W-1:0]   wb_tag,
    output logic [`EXEC_XLEN-1:0]    wb_value,
    output exec_pkg::wb_src_e        wb_src,
    output logic                     alu_stall,
    output logic                     br_stall
);
    import exec_pkg::*;

    logic br_req;
    logic br_grant;
    logic alu_grant;

    // conditional branches finish without a register write
    assign br_req    = br_done && br_writes;

    // fixed priority, branch unit first
    assign br_grant  = br_req;
    assign alu_grant = alu_done && !br_req;

    assign wb_valid  = br_grant || alu_grant;
    assign wb_src    = br_grant ? WB_BRANCH : WB_ALU;
    assign wb_tag    = br_grant ? br_tag : alu_tag;
    assign wb_value  = br_grant ? br_link : alu_result;

    assign alu_stall = alu_done && !alu_grant;
    assign br_stall  = br_req && !br_grant;

endmodule

/* tb/exec_stage_chk.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_stage_chk (
    input  logic                       clock,
    input  logic                       arst_n,
    input  logic                       wb_valid,
    input  exec_pkg::wb_src_e          wb_src,
    input  logic                       alu_stall,
    input  logic                       br_stall,
    input  exec_pkg::br_task_e         br_task,
    input  logic [`EXEC_BMASK_W-1:0]   br_id,
    input  logic                       alu_done,
    input  logic [`EXEC_BMASK_W-1:0]   alu_mask,
    input  logic [`EXEC_XLEN-1:0]      alu_result,
    input  logic [`EXEC_TAG_W-1:0]     alu_tag
);
    import exec_pkg::*;

    // the granted unit is never the stalled one
    winner_not_stalled: assert property (@(posedge clock) disable iff (!arst_n)
        wb_valid |-> (wb_src == WB_BRANCH ? !br_stall : !alu_stall))
        else $error("writeback granted to a stalled unit");

    // held ALU result hit by a squash is gone one cycle later
    squash_empties_held: assert property (@(posedge clock) disable iff (!arst_n)
        (alu_stall && alu_done && br_task == SQUASH && (alu_mask & br_id) != '0)
        |=> !alu_done)
        else $error("squashed ALU result still held");

    stalled_result_stable: assert property (@(posedge clock) disable iff (!arst_n)
        alu_stall |=> ($stable(alu_result) && $stable(alu_tag)))
        else $error("ALU result changed under stall");

endmodule

/* tb/exec_stage_tb.sv */
`timescale 1ns/1ps
`include "exec_config.svh"

module exec_stage_tb;
    import isa_pkg::*;
    import exec_pkg::*;

    logic clock, arst_n, pred_taken, alu_issue, br_issue;
    rv_inst_u inst;
    logic [`EXEC_XLEN-1:0] pc, rs1_value, rs2_value, wb_value, res_target;
    opa_sel_e opa_sel;
    opb_sel_e opb_sel;
    alu_func_e alu_func;
    logic [`EXEC_TAG_W-1:0] dest_tag, wb_tag, res_tag;
    logic [`EXEC_BMASK_W-1:0] b_mask, br_id;
    br_task_e br_task;
    wb_src_e wb_src;
    logic wb_valid, res_valid, res_taken, res_mispredict, alu_stall, br_stall;
    logic [15:0] lfsr;
    int errors, test_errors, tests_run, tests_failed;

    exec_stage dut (.*);

    bind exec_stage exec_stage_chk chk (
        .clock (clock), .arst_n (arst_n), .wb_valid (wb_valid), .wb_src (wb_src),
        .alu_stall (alu_stall), .br_stall (br_stall), .br_task (br_task), .br_id (br_id),
        .alu_done (u_alu.done), .alu_mask (u_alu.held_mask),
        .alu_result (u_alu.result), .alu_tag (u_alu.done_tag)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    // 16-bit Fibonacci LFSR, taps 16 14 13 11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    // immediates straight from the bit positions in the ISA manual
    function automatic logic [31:0] imm_of(input opb_sel_e sel, input logic [31:0] w);
        case (sel)
            OPB_I_IMM: return {{20{w[31]}}, w[31:20]};
            OPB_S_IMM: return {{20{w[31]}}, w[31:25], w[11:7]};
            OPB_B_IMM: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            OPB_U_IMM: return {w[31:12], 12'b0};
            default:   return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
        endcase
    endfunction

    function automatic logic [31:0] alu_ref(input alu_func_e f, input logic [31:0] a,
                                            input logic [31:0] b);
        case (f)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_XOR:  return a ^ b;
            ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            ALU_SLTU: return {31'b0, a < b};
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            default:  return $unsigned($signed(a) >>> b[4:0]);
        endcase
    endfunction

    function automatic logic cond_ref(input logic [2:0] f3, input logic [31:0] a,
                                      input logic [31:0] b);
        case (f3)
            F3_BEQ:  return a == b;
            F3_BNE:  return a != b;
            F3_BLT:  return $signed(a) < $signed(b);
            F3_BGE:  return $signed(a) >= $signed(b);
            F3_BLTU: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp === act) else begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        $display("test %s: %s (%0d errors)", name, test_errors == 0 ? "ok" : "failed",
                 test_errors);
        tests_run++;
        if (test_errors != 0) tests_failed++;
        test_errors = 0;
    endtask

    // strobes for one edge, inputs already driven in this time step
    task automatic pulse_issue(input logic a, input logic b);
        alu_issue <= a;
        br_issue <= b;
        @(posedge clock);
        alu_issue <= 1'b0;
        br_issue <= 1'b0;
    endtask

    task automatic wait_wb(input string name, output int cycles);
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!wb_valid && cycles < 20);
        if (!wb_valid) begin
            $display("timeout: no writeback seen in test %s", name);
            errors++;
            test_errors++;
        end
    endtask

    task automatic wait_res(input string name);
        int cycles;
        cycles = 0;
        do begin
            @(negedge clock);
            cycles++;
        end while (!res_valid && cycles < 20);
        if (!res_valid) begin
            $display("timeout: no branch resolution seen in test %s", name);
            errors++;
            test_errors++;
        end
    endtask

    task automatic test_alu_ops();
        logic [31:0] w, p, r1, r2, a, b;
        logic [5:0] tag;
        int n;
        for (int f = 0; f < 10; f++) begin
            for (int sa = 0; sa < 4; sa++) begin
                for (int sb = 0; sb < 6; sb++) begin
                    w = rand_bits(32);
                    p = {30'(rand_bits(30)), 2'b00};
                    r1 = rand_bits(32);
                    r2 = rand_bits(32);
                    tag = 6'(rand_bits(6));
                    a = (sa == 0) ? r1 : (sa == 1) ? p + 32'd4 : (sa == 2) ? p : 32'd0;
                    b = (sb == 0) ? r2 : imm_of(opb_sel_e'(sb), w);
                    @(posedge clock);
                    inst <= w;
                    pc <= p;
                    rs1_value <= r1;
                    rs2_value <= r2;
                    opa_sel <= opa_sel_e'(sa);
                    opb_sel <= opb_sel_e'(sb);
                    alu_func <= alu_func_e'(f);
                    dest_tag <= tag;
                    pulse_issue(1'b1, 1'b0);
                    wait_wb("alu_ops", n);
                    check_value("alu_ops latency", 32'd1, 32'(n));
                    check_value("alu_ops value", alu_ref(alu_func_e'(f), a, b), wb_value);
                    check_value("alu_ops tag", 32'(tag), 32'(wb_tag));
                    check_value("alu_ops src", 32'(WB_ALU), 32'(wb_src));
                end
            end
        end
        end_test("alu_ops");
    endtask

    task automatic test_branches();
        logic [2:0] f3s [6];
        logic [31:0] w, p, r1, r2;
        logic [5:0] tag;
        logic pred, tk;
        f3s = '{F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};
        for (int f = 0; f < 6; f++) begin
            for (int k = 0; k < 4; k++) begin
                w = {17'(rand_bits(17)), f3s[f], 5'(rand_bits(5)), OPC_BRANCH};
                p = {30'(rand_bits(30)), 2'b00};
                r1 = rand_bits(32);
                // equal operands on odd passes
                r2 = k[0] ? r1 : rand_bits(32);
                pred = 1'(rand_bits(1));
                tag = 6'(rand_bits(6));
                tk = cond_ref(f3s[f], r1, r2);
                @(posedge clock);
                inst <= w;
                pc <= p;
                rs1_value <= r1;
                rs2_value <= r2;
                pred_taken <= pred;
                dest_tag <= tag;
                pulse_issue(1'b0, 1'b1);
                wait_res("branches");
                check_value("branches taken", 32'(tk), 32'(res_taken));
                check_value("branches target", p + imm_of(OPB_B_IMM, w), res_target);
                check_value("branches mispredict", 32'(tk != pred), 32'(res_mispredict));
                check_value("branches tag", 32'(tag), 32'(res_tag));
                check_value("branches no writeback", 32'd0, 32'(wb_valid));
            end
        end
        end_test("branches");
    endtask

    task automatic test_jumps();
        logic [31:0] w, p, r1, tgt;
        logic [5:0] tag;
        int n;
        for (int k = 0; k < 8; k++) begin
            w = {25'(rand_bits(25)), k[0] ? OPC_JALR : OPC_JAL};
            p = {30'(rand_bits(30)), 2'b00};
            r1 = rand_bits(32);
            tag = 6'(rand_bits(6));
            tgt = k[0] ? ((r1 + imm_of(OPB_I_IMM, w)) & ~32'd1) : p + imm_of(OPB_J_IMM, w);
            @(posedge clock);
            inst <= w;
            pc <= p;
            rs1_value <= r1;
            dest_tag <= tag;
            pred_taken <= 1'b1;
            pulse_issue(1'b0, 1'b1);
            wait_wb("jumps", n);
            check_value("jumps link", p + 32'd4, wb_value);
            check_value("jumps tag", 32'(tag), 32'(wb_tag));
            check_value("jumps src", 32'(WB_BRANCH), 32'(wb_src));
            check_value("jumps resolved", 32'd1, 32'(res_valid && res_taken));
            check_value("jumps target", tgt, res_target);
        end
        end_test("jumps");
    endtask

    // jump and ALU op in the same edge so both finish together
    task automatic start_pair(input logic [31:0] r1, input logic [31:0] r2,
                              input logic [5:0] tag, input logic [3:0] mask);
        @(posedge clock);
        inst <= {25'd0, OPC_JAL};
        pc <= 32'h100;
        rs1_value <= r1;
        rs2_value <= r2;
        opa_sel <= OPA_RS1;
        opb_sel <= OPB_RS2;
        alu_func <= ALU_ADD;
        dest_tag <= tag;
        b_mask <= mask;
        pulse_issue(1'b1, 1'b1);
    endtask

    task automatic test_contention();
        logic [31:0] r1, r2;
        int n;
        r1 = rand_bits(32);
        r2 = rand_bits(32);
        start_pair(r1, r2, 6'd9, 4'd0);
        wait_wb("contention", n);
        check_value("contention first src", 32'(WB_BRANCH), 32'(wb_src));
        check_value("contention link", 32'h104, wb_value);
        check_value("contention stall", 32'd1, 32'(alu_stall));
        check_value("contention br stall", 32'd0, 32'(br_stall));
        @(negedge clock);
        check_value("contention second src", 32'(WB_ALU), 32'(wb_src));
        check_value("contention alu value", r1 + r2, wb_value);
        check_value("contention alu stall", 32'd0, 32'(alu_stall));
        end_test("contention");
    endtask

    task automatic test_squash();
        int n;
        start_pair(32'd1, 32'd2, 6'd20, 4'b0010);
        // squash the held ALU result and a fresh jump in one cycle
        br_task <= SQUASH;
        br_id <= 4'b0010;
        dest_tag <= 6'd21;
        br_issue <= 1'b1;
        @(negedge clock);
        check_value("squash jump tag", 32'd20, 32'(wb_tag));
        @(posedge clock);
        br_task <= NONE;
        br_issue <= 1'b0;
        b_mask <= 4'd0;
        for (int i = 0; i < 4; i++) begin
            @(negedge clock);
            check_value("squash no writeback", 32'd0, 32'(wb_valid));
        end
        @(posedge clock);
        br_task <= SQUASH;
        br_id <= 4'b0010;
        b_mask <= 4'b0100;
        dest_tag <= 6'd22;
        pulse_issue(1'b1, 1'b0);
        br_task <= NONE;
        wait_wb("squash", n);
        check_value("squash survivor tag", 32'd22, 32'(wb_tag));
        check_value("squash survivor value", 32'd3, wb_value);
        end_test("squash");
    endtask

    task automatic test_clear_squash();
        int n;
        start_pair(32'd40, 32'd2, 6'd30, 4'b0100);
        // second jump keeps the ALU stalled while the mask is cleared
        br_task <= CLEAR;
        br_id <= 4'b0100;
        b_mask <= 4'd0;
        dest_tag <= 6'd31;
        br_issue <= 1'b1;
        @(posedge clock);
        br_issue <= 1'b0;
        br_task <= SQUASH;
        wait_wb("clear_squash", n);
        check_value("clear_squash second jump", 32'd31, 32'(wb_tag));
        @(posedge clock);
        br_task <= NONE;
        @(negedge clock);
        check_value("clear_squash alu valid", 32'd1, 32'(wb_valid));
        check_value("clear_squash alu tag", 32'd30, 32'(wb_tag));
        check_value("clear_squash alu value", 32'd42, wb_value);
        end_test("clear_squash");
    endtask

    initial begin
        lfsr = 16'd16628;
        errors = 0;
        test_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        arst_n = 1'b0;
        inst = '0;
        pc = '0;
        rs1_value = '0;
        rs2_value = '0;
        opa_sel = OPA_RS1;
        opb_sel = OPB_RS2;
        alu_func = ALU_ADD;
        dest_tag = '0;
        b_mask = '0;
        pred_taken = 1'b0;
        alu_issue = 1'b0;
        br_issue = 1'b0;
        br_task = NONE;
        br_id = '0;
        repeat (10) @(posedge clock);
        arst_n <= 1'b1;
        test_alu_ops();
        test_branches();
        test_jumps();
        test_contention();
        test_squash();
        test_clear_squash();
        repeat (2) @(posedge clock);
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule
